/* sources.f */
natv_pkg.sv
nmi_gpio.sv
nmi_timer.sv
nmi_clint.sv
ip_natv_wrapper.sv
natv_properties.sv
tb_ip_natv_wrapper.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only when the pass line is printed
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
  --top-module tb_ip_natv_wrapper -o tb_sim

out=$(./obj_dir/tb_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'test passed'; then
  exit 0
fi
echo "simulation did not report a pass" >&2
exit 1

/* tb_ip_natv_wrapper.sv */
// testbench for ip_natv_wrapper with GPIO_W 8; stops at the first error, every wait is bounded
`timescale 1ns/1ps
`default_nettype none

module tb_ip_natv_wrapper
  import natv_pkg::*;
;

  localparam int GPIO_W       = 8;
  localparam int BUS_TIMEOUT  = 20;
  localparam int IRQ_TIMEOUT  = 200;
  localparam int POLL_TIMEOUT = 10;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_WAIT_IRQ
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] exp;
    logic [31:0] mask;
  } stim_t;

  logic              clk;
  logic              rst_n;
  logic              nmi_valid;
  logic [NMI_AW-1:0] nmi_addr;
  logic [NMI_DW-1:0] nmi_wdata;
  logic [NMI_SW-1:0] nmi_wstrb;
  logic              nmi_ready;
  logic [NMI_DW-1:0] nmi_rdata;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;
  logic [IRQ_W-1:0]  irq;
  stim_t             stim_q[$];

  ip_natv_wrapper #(
    .GPIO_W(GPIO_W)
  ) dut0 (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .nmi_valid_i(nmi_valid),
    .nmi_addr_i (nmi_addr),
    .nmi_wdata_i(nmi_wdata),
    .nmi_wstrb_i(nmi_wstrb),
    .nmi_ready_o(nmi_ready),
    .nmi_rdata_o(nmi_rdata),
    .gpio_i     (gpio_in),
    .gpio_o     (gpio_out),
    .gpio_oe_o  (gpio_oe),
    .irq_o      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] reg_addr(input logic [7:0] page, input logic [2:0] off);
    return {NATV_IP_START, 12'h000, page, 3'b000, off, 2'b00};
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rdata(input string name, input logic [NMI_DW-1:0] got,
                             input logic [NMI_DW-1:0] exp, input logic [NMI_DW-1:0] mask);
    if ((got & mask) !== (exp & mask)) begin
      fail_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h", $time, name,
                         got & mask, exp & mask));
    end
  endtask

  task automatic check_irq(input logic [IRQ_W-1:0] got, input logic [IRQ_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t ns: irq_o got %b expected %b", $time, got, exp));
    end
  endtask

  task automatic check_gpio(input string name, input logic [GPIO_W-1:0] got,
                            input logic [GPIO_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // called 1 ns after a rising edge, returns at the same point
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    int count;
    count     = 0;
    nmi_valid = 1'b1;
    nmi_addr  = addr;
    nmi_wdata = wdata;
    nmi_wstrb = wstrb;
    @(negedge clk);
    while (!nmi_ready) begin
      count++;
      if (count > BUS_TIMEOUT) begin
        fail_run($sformatf("bus access to %h got no ready within %0d cycles", addr, count));
      end
      @(negedge clk);
    end
    rdata = nmi_rdata;
    @(posedge clk);
    #1;
    nmi_valid = 1'b0;
    nmi_wstrb = '0;
  endtask

  // mask picks the bits to wait on, the whole vector is checked after
  task automatic wait_irq(input logic [IRQ_W-1:0] exp, input logic [IRQ_W-1:0] mask);
    int count;
    count = 0;
    @(negedge clk);
    while ((irq & mask) !== (exp & mask)) begin
      count++;
      if (count > IRQ_TIMEOUT) begin
        fail_run($sformatf("irq_o never reached %b under mask %b", exp, mask));
      end
      @(negedge clk);
    end
    check_irq(irq, exp);
    @(posedge clk);
    #1;
  endtask

  task automatic add_entry(input op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb, input logic [31:0] exp,
                           input logic [31:0] mask);
    stim_q.push_back('{op, addr, wdata, wstrb, exp, mask});
  endtask

  task automatic build_table();
    // gpio direction, output and byte strobes
    add_entry(OP_WRITE, reg_addr(NMI_GPIO_START, GPIO_DIR), 32'hA5, 4'hF, 0, 0);
    add_entry(OP_WRITE, reg_addr(NMI_GPIO_START, GPIO_OUT), 32'h3C, 4'hF, 0, 0);
    add_entry(OP_READ, reg_addr(NMI_GPIO_START, GPIO_DIR), 0, 0, 32'hA5, 32'hFFFF_FFFF);
    add_entry(OP_READ, reg_addr(NMI_GPIO_START, GPIO_OUT), 0, 0, 32'h3C, 32'hFFFF_FFFF);
    add_entry(OP_WRITE, reg_addr(NMI_GPIO_START, GPIO_OUT), 32'h0000_FF00, 4'h2, 0, 0);
    add_entry(OP_READ, reg_addr(NMI_GPIO_START, GPIO_OUT), 0, 0, 32'h3C, 32'hFFFF_FFFF);
    add_entry(OP_WRITE, reg_addr(NMI_GPIO_START, GPIO_OUT), 32'hFFFF_FF5A, 4'h1, 0, 0);
    add_entry(OP_READ, reg_addr(NMI_GPIO_START, GPIO_OUT), 0, 0, 32'h5A, 32'hFFFF_FFFF);
    // timer 0, then stop counting so the cleared flag stays clear
    add_entry(OP_WRITE, reg_addr(NMI_TIM0_START, TIM_PSCR), 32'd0, 4'hF, 0, 0);
    add_entry(OP_WRITE, reg_addr(NMI_TIM0_START, TIM_CMP), 32'd5, 4'hF, 0, 0);
    add_entry(OP_WRITE, reg_addr(NMI_TIM0_START, TIM_CTRL), 32'd3, 4'hF, 0, 0);
    add_entry(OP_WAIT_IRQ, 0, 0, 0, 32'b0100, 32'b0100);
    add_entry(OP_READ, reg_addr(NMI_TIM0_START, TIM_STAT), 0, 0, 32'd1, 32'hFFFF_FFFF);
    add_entry(OP_WRITE, reg_addr(NMI_TIM0_START, TIM_CTRL), 32'd2, 4'hF, 0, 0);
    add_entry(OP_WRITE, reg_addr(NMI_TIM0_START, TIM_STAT), 32'd0, 4'hF, 0, 0);
    add_entry(OP_WAIT_IRQ, 0, 0, 0, 32'b0000, 32'b0100);
    add_entry(OP_READ, reg_addr(NMI_TIM0_START, TIM_STAT), 0, 0, 32'd0, 32'hFFFF_FFFF);
    // timer 1 with a prescaler
    add_entry(OP_WRITE, reg_addr(NMI_TIM1_START, TIM_PSCR), 32'd1, 4'hF, 0, 0);
    add_entry(OP_WRITE, reg_addr(NMI_TIM1_START, TIM_CMP), 32'd5, 4'hF, 0, 0);
    add_entry(OP_WRITE, reg_addr(NMI_TIM1_START, TIM_CTRL), 32'd3, 4'hF, 0, 0);
    add_entry(OP_WAIT_IRQ, 0, 0, 0, 32'b1000, 32'b1000);
    add_entry(OP_WRITE, reg_addr(NMI_TIM1_START, TIM_CTRL), 32'd2, 4'hF, 0, 0);
    add_entry(OP_WRITE, reg_addr(NMI_TIM1_START, TIM_STAT), 32'd0, 4'hF, 0, 0);
    add_entry(OP_WAIT_IRQ, 0, 0, 0, 32'b0000, 32'b1000);
    // software interrupt
    add_entry(OP_WRITE, reg_addr(NMI_CLINT_START, CLINT_MSIP), 32'd1, 4'hF, 0, 0);
    add_entry(OP_WAIT_IRQ, 0, 0, 0, 32'b0001, 32'b0001);
    add_entry(OP_WRITE, reg_addr(NMI_CLINT_START, CLINT_MSIP), 32'd0, 4'hF, 0, 0);
    add_entry(OP_WAIT_IRQ, 0, 0, 0, 32'b0000, 32'b0001);
    // unmapped space and page, then gpio must be unchanged
    add_entry(OP_WRITE, 32'h7000_0004, 32'hFFFF_FFFF, 4'hF, 0, 0);
    add_entry(OP_READ, 32'h7000_0004, 0, 0, 32'd0, 32'hFFFF_FFFF);
    add_entry(OP_WRITE, 32'h1000_1004, 32'hFFFF_FFFF, 4'hF, 0, 0);
    add_entry(OP_READ, 32'h1000_1004, 0, 0, 32'd0, 32'hFFFF_FFFF);
    add_entry(OP_READ, reg_addr(NMI_GPIO_START, GPIO_OUT), 0, 0, 32'h5A, 32'hFFFF_FFFF);
  endtask

  initial begin
    stim_t       e;
    logic [31:0] rd;
    logic [31:0] t1;
    logic [31:0] t2;
    logic [31:0] rnd;
    int          tries;

    void'($urandom(78796));
    rst_n     = 1'b0;
    nmi_valid = 1'b0;
    nmi_addr  = '0;
    nmi_wdata = '0;
    nmi_wstrb = '0;
    gpio_in   = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_irq(irq, '0);

    build_table();
    foreach (stim_q[i]) begin
      e = stim_q[i];
      case (e.op)
        OP_WRITE: bus_access(e.addr, e.wdata, e.wstrb, rd);
        OP_READ: begin
          bus_access(e.addr, '0, '0, rd);
          check_rdata($sformatf("rdata at %h", e.addr), rd, e.exp, e.mask);
        end
        OP_WAIT_IRQ: wait_irq(e.exp[IRQ_W-1:0], e.mask[IRQ_W-1:0]);
        default: fail_run("unknown table op");
      endcase
    end
    check_gpio("gpio_oe_o", gpio_oe, 8'hA5);
    check_gpio("gpio_o", gpio_out, 8'h5A);

    // input pins arrive through the synchronizer
    gpio_in = 8'h96;
    tries   = 0;
    bus_access(reg_addr(NMI_GPIO_START, GPIO_IN), '0, '0, rd);
    while (rd[GPIO_W-1:0] !== 8'h96) begin
      tries++;
      if (tries > POLL_TIMEOUT) begin
        fail_run("GPIO_IN never showed the driven pins");
      end
      bus_access(reg_addr(NMI_GPIO_START, GPIO_IN), '0, '0, rd);
    end
    // bits above the port width read zero
    check_rdata("GPIO_IN", rd, 32'h96, 32'hFFFF_FFFF);

    // machine timer
    bus_access(reg_addr(NMI_CLINT_START, CLINT_MTIME_LO), '0, '0, t1);
    bus_access(reg_addr(NMI_CLINT_START, CLINT_MTIME_LO), '0, '0, t2);
    if (!(t2 > t1)) begin
      fail_run($sformatf("mtime did not advance, %h then %h", t1, t2));
    end
    bus_access(reg_addr(NMI_CLINT_START, CLINT_MTIMECMP_HI), 32'd0, 4'hF, rd);
    bus_access(reg_addr(NMI_CLINT_START, CLINT_MTIMECMP_LO), t2 + 32'd50, 4'hF, rd);
    wait_irq(4'b0010, 4'b0010);
    bus_access(reg_addr(NMI_CLINT_START, CLINT_MTIMECMP_LO), 32'hFFFF_FFFF, 4'hF, rd);
    wait_irq(4'b0000, 4'b0010);

    // random readback, both registers are a full 32 bits wide
    for (int i = 0; i < 4; i++) begin
      rnd = $urandom;
      bus_access(reg_addr(NMI_TIM0_START, TIM_CMP), rnd, 4'hF, rd);
      bus_access(reg_addr(NMI_TIM0_START, TIM_CMP), '0, '0, rd);
      check_rdata("TIM_CMP", rd, rnd, 32'hFFFF_FFFF);
      rnd = $urandom;
      bus_access(reg_addr(NMI_CLINT_START, CLINT_MTIMECMP_LO), rnd, 4'hF, rd);
      bus_access(reg_addr(NMI_CLINT_START, CLINT_MTIMECMP_LO), '0, '0, rd);
      check_rdata("MTIMECMP_LO", rd, rnd, 32'hFFFF_FFFF);
    end

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* natv_properties.sv */
// bus protocol and reset checks on the top level, sampled at the rising clock edge only
`timescale 1ns/1ps
`default_nettype none

module natv_properties
  import natv_pkg::*;
(
  input logic             clk_i,
  input logic             rst_n_i,
  input logic             nmi_valid_i,
  input logic             nmi_ready_i,
  input logic [IRQ_W-1:0] irq_i
);

  // registered ready, so the request must already have been there one edge earlier
  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    nmi_ready_i |-> nmi_valid_i && $past(nmi_valid_i))
    else $error("ready high without a held valid");

  ready_is_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    nmi_ready_i |=> !nmi_ready_i) else $error("ready high on two cycles in a row");

  // irq registers clear on the reset edge
  irq_low_after_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> irq_i == '0) else $error("irq not zero after reset");

endmodule

bind ip_natv_wrapper natv_properties u_natv_properties (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .nmi_valid_i(nmi_valid_i),
  .nmi_ready_i(nmi_ready_o),
  .irq_i      (irq_o)
);

`default_nettype wire

/* ip_natv_wrapper.sv */
// peripheral top; only space 4'h1 pages 0x00..0x03 are mapped, anything else reads zero and drops writes
`timescale 1ns/1ps
`default_nettype none

module ip_natv_wrapper
  import natv_pkg::*;
#(
  parameter int GPIO_W = 8
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              nmi_valid_i,
  input  logic [NMI_AW-1:0] nmi_addr_i,
  input  logic [NMI_DW-1:0] nmi_wdata_i,
  input  logic [NMI_SW-1:0] nmi_wstrb_i,
  output logic              nmi_ready_o,
  output logic [NMI_DW-1:0] nmi_rdata_o,
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_oe_o,
  output logic [IRQ_W-1:0]  irq_o
);

  logic              s_ip_sel;
  logic              s_gpio_valid, s_gpio_ready;
  logic              s_tim0_valid, s_tim0_ready;
  logic              s_tim1_valid, s_tim1_ready;
  logic              s_clint_valid, s_clint_ready;
  logic              s_dflt_valid, s_dflt_ready_q;
  logic [NMI_DW-1:0] s_gpio_rdata, s_tim0_rdata, s_tim1_rdata, s_clint_rdata;
  logic              s_tim0_irq, s_tim1_irq;
  logic              s_clint_sfr_irq, s_clint_tmr_irq;

  // page decode
  assign s_ip_sel      = (nmi_addr_i[31:28] == NATV_IP_START);
  assign s_gpio_valid  = nmi_valid_i & s_ip_sel & (nmi_addr_i[15:8] == NMI_GPIO_START);
  assign s_tim0_valid  = nmi_valid_i & s_ip_sel & (nmi_addr_i[15:8] == NMI_TIM0_START);
  assign s_tim1_valid  = nmi_valid_i & s_ip_sel & (nmi_addr_i[15:8] == NMI_TIM1_START);
  assign s_clint_valid = nmi_valid_i & s_ip_sel & (nmi_addr_i[15:8] == NMI_CLINT_START);
  assign s_dflt_valid  = nmi_valid_i & ~(s_gpio_valid | s_tim0_valid |
                                         s_tim1_valid | s_clint_valid);

  // default responder, same one-cycle handshake as the slaves
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_dflt_ready_q <= 1'b0;
    end else begin
      s_dflt_ready_q <= s_dflt_valid & ~s_dflt_ready_q;
    end
  end

  assign nmi_ready_o = (s_gpio_valid  & s_gpio_ready)  |
                       (s_tim0_valid  & s_tim0_ready)  |
                       (s_tim1_valid  & s_tim1_ready)  |
                       (s_clint_valid & s_clint_ready) |
                       (s_dflt_valid  & s_dflt_ready_q);

  // unmapped accesses add no term, so they read zero
  assign nmi_rdata_o = ({NMI_DW{s_gpio_valid  & s_gpio_ready}}  & s_gpio_rdata) |
                       ({NMI_DW{s_tim0_valid  & s_tim0_ready}}  & s_tim0_rdata) |
                       ({NMI_DW{s_tim1_valid  & s_tim1_ready}}  & s_tim1_rdata) |
                       ({NMI_DW{s_clint_valid & s_clint_ready}} & s_clint_rdata);

  assign irq_o[IRQ_CLINT_SFR] = s_clint_sfr_irq;
  assign irq_o[IRQ_CLINT_TMR] = s_clint_tmr_irq;
  assign irq_o[IRQ_TIM0]      = s_tim0_irq;
  assign irq_o[IRQ_TIM1]      = s_tim1_irq;

  nmi_gpio #(
    .GPIO_W(GPIO_W)
  ) u_nmi_gpio (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .nmi_valid_i(s_gpio_valid),
    .nmi_addr_i (nmi_addr_i),
    .nmi_wdata_i(nmi_wdata_i),
    .nmi_wstrb_i(nmi_wstrb_i),
    .nmi_ready_o(s_gpio_ready),
    .nmi_rdata_o(s_gpio_rdata),
    .gpio_i     (gpio_i),
    .gpio_o     (gpio_o),
    .gpio_oe_o  (gpio_oe_o)
  );

  nmi_timer u_nmi_timer0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .nmi_valid_i(s_tim0_valid),
    .nmi_addr_i (nmi_addr_i),
    .nmi_wdata_i(nmi_wdata_i),
    .nmi_wstrb_i(nmi_wstrb_i),
    .nmi_ready_o(s_tim0_ready),
    .nmi_rdata_o(s_tim0_rdata),
    .irq_o      (s_tim0_irq)
  );

  nmi_timer u_nmi_timer1 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .nmi_valid_i(s_tim1_valid),
    .nmi_addr_i (nmi_addr_i),
    .nmi_wdata_i(nmi_wdata_i),
    .nmi_wstrb_i(nmi_wstrb_i),
    .nmi_ready_o(s_tim1_ready),
    .nmi_rdata_o(s_tim1_rdata),
    .irq_o      (s_tim1_irq)
  );

  nmi_clint u_nmi_clint (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .nmi_valid_i(s_clint_valid),
    .nmi_addr_i (nmi_addr_i),
    .nmi_wdata_i(nmi_wdata_i),
    .nmi_wstrb_i(nmi_wstrb_i),
    .nmi_ready_o(s_clint_ready),
    .nmi_rdata_o(s_clint_rdata),
    .sfr_irq_o  (s_clint_sfr_irq),
    .tmr_irq_o  (s_clint_tmr_irq)
  );

endmodule

`default_nettype wire

/* nmi_clint.sv */
// CLINT with msip and a 64-bit mtime; the two mtime halves are read in separate accesses, no latching
`timescale 1ns/1ps
`default_nettype none

module nmi_clint
  import natv_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              nmi_valid_i,
  input  logic [NMI_AW-1:0] nmi_addr_i,
  input  logic [NMI_DW-1:0] nmi_wdata_i,
  input  logic [NMI_SW-1:0] nmi_wstrb_i,
  output logic              nmi_ready_o,
  output logic [NMI_DW-1:0] nmi_rdata_o,
  output logic              sfr_irq_o,
  output logic              tmr_irq_o
);

  clint_reg_e        s_reg;
  logic              s_ready_q;
  logic              s_wr_en;
  logic [NMI_DW-1:0] s_wr_val;
  logic              s_msip_q;
  logic [63:0]       s_mtime_q;
  logic [63:0]       s_mtimecmp_q;
  logic              s_tmr_irq_q;

  assign s_reg    = clint_reg_e'(nmi_addr_i[4:2]);
  assign s_wr_en  = nmi_valid_i & s_ready_q & (|nmi_wstrb_i);
  assign s_wr_val = wstrb_merge(nmi_rdata_o, nmi_wdata_i, nmi_wstrb_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_ready_q <= 1'b0;
    end else begin
      s_ready_q <= nmi_valid_i & ~s_ready_q;
    end
  end

  // software interrupt, bit 0 only
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_msip_q <= 1'b0;
    end else if (s_wr_en && s_reg == CLINT_MSIP) begin
      s_msip_q <= s_wr_val[0];
    end
  end

  // free running, one count per clock
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_mtime_q <= '0;
    end else begin
      s_mtime_q <= s_mtime_q + 64'd1;
    end
  end

  // all ones keeps the timer interrupt quiet until software arms it
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_mtimecmp_q <= '1;
    end else if (s_wr_en) begin
      if (s_reg == CLINT_MTIMECMP_LO) begin
        s_mtimecmp_q[31:0] <= s_wr_val;
      end
      if (s_reg == CLINT_MTIMECMP_HI) begin
        s_mtimecmp_q[63:32] <= s_wr_val;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_tmr_irq_q <= 1'b0;
    end else begin
      s_tmr_irq_q <= (s_mtime_q >= s_mtimecmp_q);
    end
  end

  always_comb begin
    nmi_rdata_o = '0;
    case (s_reg)
      CLINT_MSIP:        nmi_rdata_o[0] = s_msip_q;
      CLINT_MTIME_LO:    nmi_rdata_o    = s_mtime_q[31:0];
      CLINT_MTIME_HI:    nmi_rdata_o    = s_mtime_q[63:32];
      CLINT_MTIMECMP_LO: nmi_rdata_o    = s_mtimecmp_q[31:0];
      CLINT_MTIMECMP_HI: nmi_rdata_o    = s_mtimecmp_q[63:32];
      default:           nmi_rdata_o    = '0;
    endcase
  end

  assign nmi_ready_o = s_ready_q;
  assign sfr_irq_o   = s_msip_q;
  assign tmr_irq_o   = s_tmr_irq_q;

endmodule

`default_nettype wire

/* nmi_timer.sv */
// prescaled compare timer; CNT wraps to zero on match, and a match in the STAT write cycle wins
`timescale 1ns/1ps
`default_nettype none

module nmi_timer
  import natv_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              nmi_valid_i,
  input  logic [NMI_AW-1:0] nmi_addr_i,
  input  logic [NMI_DW-1:0] nmi_wdata_i,
  input  logic [NMI_SW-1:0] nmi_wstrb_i,
  output logic              nmi_ready_o,
  output logic [NMI_DW-1:0] nmi_rdata_o,
  output logic              irq_o
);

  tim_reg_e          s_reg;
  logic              s_ready_q;
  logic              s_wr_en;
  logic [NMI_DW-1:0] s_wr_val;
  logic [1:0]        s_ctrl_q;
  logic [NMI_DW-1:0] s_pscr_q;
  logic [NMI_DW-1:0] s_cmp_q;
  logic [NMI_DW-1:0] s_cnt_q;
  logic [NMI_DW-1:0] s_psc_q;
  logic              s_stat_q;
  logic              s_irq_q;
  logic              s_tick;
  logic              s_match;

  assign s_reg    = tim_reg_e'(nmi_addr_i[4:2]);
  assign s_wr_en  = nmi_valid_i & s_ready_q & (|nmi_wstrb_i);
  assign s_wr_val = wstrb_merge(nmi_rdata_o, nmi_wdata_i, nmi_wstrb_i);

  // ctrl[0] enable, ctrl[1] irq enable
  assign s_tick  = s_ctrl_q[0] & (s_psc_q == s_pscr_q);
  assign s_match = s_tick & (s_cnt_q == s_cmp_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_ready_q <= 1'b0;
    end else begin
      s_ready_q <= nmi_valid_i & ~s_ready_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_ctrl_q <= '0;
      s_pscr_q <= '0;
      s_cmp_q  <= '0;
    end else if (s_wr_en) begin
      case (s_reg)
        TIM_CTRL: s_ctrl_q <= s_wr_val[1:0];
        TIM_PSCR: s_pscr_q <= s_wr_val;
        TIM_CMP:  s_cmp_q  <= s_wr_val;
        default:  s_ctrl_q <= s_ctrl_q;
      endcase
    end
  end

  // prescaler and counter stop while disabled, CNT holds its value
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_psc_q <= '0;
      s_cnt_q <= '0;
    end else if (!s_ctrl_q[0]) begin
      s_psc_q <= '0;
    end else if (s_tick) begin
      s_psc_q <= '0;
      s_cnt_q <= s_match ? '0 : s_cnt_q + 1'b1;
    end else begin
      s_psc_q <= s_psc_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_stat_q <= 1'b0;
      s_irq_q  <= 1'b0;
    end else begin
      if (s_match) begin
        s_stat_q <= 1'b1;
      end else if (s_wr_en && s_reg == TIM_STAT) begin
        s_stat_q <= 1'b0;
      end
      s_irq_q <= s_stat_q & s_ctrl_q[1];
    end
  end

  always_comb begin
    nmi_rdata_o = '0;
    case (s_reg)
      TIM_CTRL: nmi_rdata_o[1:0] = s_ctrl_q;
      TIM_PSCR: nmi_rdata_o      = s_pscr_q;
      TIM_CMP:  nmi_rdata_o      = s_cmp_q;
      TIM_CNT:  nmi_rdata_o      = s_cnt_q;
      TIM_STAT: nmi_rdata_o[0]   = s_stat_q;
      default:  nmi_rdata_o      = '0;
    endcase
  end

  assign nmi_ready_o = s_ready_q;
  assign irq_o       = s_irq_q;

endmodule

`default_nettype wire

/* nmi_gpio.sv */
// GPIO register block; GPIO_W must be 1 to 32 and GPIO_IN lags the pins by two clocks
`timescale 1ns/1ps
`default_nettype none

module nmi_gpio
  import natv_pkg::*;
#(
  parameter int GPIO_W = 8
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              nmi_valid_i,
  input  logic [NMI_AW-1:0] nmi_addr_i,
  input  logic [NMI_DW-1:0] nmi_wdata_i,
  input  logic [NMI_SW-1:0] nmi_wstrb_i,
  output logic              nmi_ready_o,
  output logic [NMI_DW-1:0] nmi_rdata_o,
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_oe_o
);

  gpio_reg_e         s_reg;
  logic              s_ready_q;
  logic              s_wr_en;
  logic [NMI_DW-1:0] s_wr_val;
  logic [GPIO_W-1:0] s_dir_q;
  logic [GPIO_W-1:0] s_out_q;
  logic [GPIO_W-1:0] s_in_meta_q;
  logic [GPIO_W-1:0] s_in_sync_q;

  assign s_reg    = gpio_reg_e'(nmi_addr_i[4:2]);
  assign s_wr_en  = nmi_valid_i & s_ready_q & (|nmi_wstrb_i);
  assign s_wr_val = wstrb_merge(nmi_rdata_o, nmi_wdata_i, nmi_wstrb_i);

  // one pulse per request, never back to back
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_ready_q <= 1'b0;
    end else begin
      s_ready_q <= nmi_valid_i & ~s_ready_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_dir_q <= '0;
      s_out_q <= '0;
    end else if (s_wr_en) begin
      if (s_reg == GPIO_DIR) begin
        s_dir_q <= s_wr_val[GPIO_W-1:0];
      end
      if (s_reg == GPIO_OUT) begin
        s_out_q <= s_wr_val[GPIO_W-1:0];
      end
    end
  end

  // input synchronizer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_in_meta_q <= '0;
      s_in_sync_q <= '0;
    end else begin
      s_in_meta_q <= gpio_i;
      s_in_sync_q <= s_in_meta_q;
    end
  end

  // upper bits beyond GPIO_W read zero
  always_comb begin
    nmi_rdata_o = '0;
    case (s_reg)
      GPIO_DIR: nmi_rdata_o[GPIO_W-1:0] = s_dir_q;
      GPIO_OUT: nmi_rdata_o[GPIO_W-1:0] = s_out_q;
      GPIO_IN:  nmi_rdata_o[GPIO_W-1:0] = s_in_sync_q;
      default:  nmi_rdata_o = '0;
    endcase
  end

  assign nmi_ready_o = s_ready_q;
  assign gpio_o      = s_out_q;
  assign gpio_oe_o   = s_dir_q;

endmodule

`default_nettype wire

/* natv_pkg.sv */
// bus widths, register address map and offset decodes; the map assumes a single 4-bit IP space
`default_nettype none

package natv_pkg;

  localparam int NMI_AW = 32;
  localparam int NMI_DW = 32;
  localparam int NMI_SW = NMI_DW / 8;

  // address bits 31..28
  localparam logic [3:0] NATV_IP_START = 4'h1;

  // page codes in address bits 15..8
  localparam logic [7:0] NMI_GPIO_START  = 8'h00;
  localparam logic [7:0] NMI_TIM0_START  = 8'h01;
  localparam logic [7:0] NMI_TIM1_START  = 8'h02;
  localparam logic [7:0] NMI_CLINT_START = 8'h03;

  // irq_o bit positions
  localparam int IRQ_CLINT_SFR = 0;
  localparam int IRQ_CLINT_TMR = 1;
  localparam int IRQ_TIM0      = 2;
  localparam int IRQ_TIM1      = 3;
  localparam int IRQ_W         = 4;

  // register offsets, taken from address bits 4..2
  typedef enum logic [2:0] {
    GPIO_DIR = 3'd0,
    GPIO_OUT = 3'd1,
    GPIO_IN  = 3'd2
  } gpio_reg_e;

  typedef enum logic [2:0] {
    TIM_CTRL = 3'd0,
    TIM_PSCR = 3'd1,
    TIM_CMP  = 3'd2,
    TIM_CNT  = 3'd3,
    TIM_STAT = 3'd4
  } tim_reg_e;

  typedef enum logic [2:0] {
    CLINT_MSIP        = 3'd0,
    CLINT_MTIME_LO    = 3'd1,
    CLINT_MTIME_HI    = 3'd2,
    CLINT_MTIMECMP_LO = 3'd3,
    CLINT_MTIMECMP_HI = 3'd4
  } clint_reg_e;

  // byte lanes with strobe set take new data, others keep the old value
  function automatic logic [NMI_DW-1:0] wstrb_merge(input logic [NMI_DW-1:0] old_val,
                                                    input logic [NMI_DW-1:0] new_val,
                                                    input logic [NMI_SW-1:0] strb);
    logic [NMI_DW-1:0] res;
    res = old_val;
    for (int i = 0; i < NMI_SW; i++) begin
      if (strb[i]) begin
        res[8*i+:8] = new_val[8*i+:8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire
